//--- src/funcPkg.sv
package funcPkg;

    localparam int FUNC_BITS = 128;               // truth table of a 7-variable function
    localparam int FUNC_VARS = $clog2(FUNC_BITS); // index width into a truth table
    localparam int NUM_PERMS = 6;                 // orderings of variables A, B, C
    localparam int POP_BITS  = FUNC_VARS + 1;     // popcount of a full table, 0..128

    typedef logic [FUNC_BITS-1:0] boolFunc;

    // value is the validMask bit the permutation occupies
    typedef enum logic [2:0] {
        ABC = 3'd5,
        ACB = 3'd4,
        BAC = 3'd3,
        BCA = 3'd2,
        CAB = 3'd1,
        CBA = 3'd0
    } permId;

    typedef struct packed {
        boolFunc [NUM_PERMS-1:0] bots;      // permuted bots, indexed by permId
        logic [NUM_PERMS-1:0]    validMask; // permuted bot stays inside top
    } permSet;

    // source bit of the bot for bit k of the permuted bot
    // A, B, C live in index bits 4, 5, 6; bits 3..0 pass straight through
    function automatic logic [FUNC_VARS-1:0] srcIndex(permId p, logic [FUNC_VARS-1:0] k);
        logic a;
        logic b;
        logic c;
        logic [2:0] src; // {bit6, bit5, bit4} of the source index
        a = k[4];
        b = k[5];
        c = k[6];
        case (p)
            ABC:     src = {c, b, a}; // identity
            ACB:     src = {b, c, a}; // swap B and C
            BAC:     src = {c, a, b}; // swap A and B
            BCA:     src = {a, c, b}; // rotate
            CAB:     src = {b, a, c}; // rotate the other way
            default: src = {a, b, c}; // CBA, swap A and C
        endcase
        return {src, k[3:0]};
    endfunction

endpackage

//--- src/streamPkg.sv
package streamPkg;

    import funcPkg::*;

    localparam int INDEX_BITS = 23; // bots since the last top load
    localparam int COUNT_BITS = 3;  // valid permutations, 0..6
    localparam int SUM_BITS   = 38; // summed uncovered top bits

    // one result per bot, msb first
    typedef struct packed {
        logic [INDEX_BITS-1:0] botIndex;
        logic [COUNT_BITS-1:0] pcoeffCount;
        logic [SUM_BITS-1:0]   summedData;
    } resultWord;

    // RUN accepts bots and tops
    // LOAD_TOP is the idle cycle that follows a top load
    typedef enum logic {
        LOAD_TOP = 1'b0,
        RUN      = 1'b1
    } mgrState;

    // what enters the count pipeline with acceptStrobe
    typedef struct packed {
        logic [INDEX_BITS-1:0] botIndex;
        permSet                perms;
    } stageRec;

endpackage

//--- src/permuteCheck.sv
`timescale 1ns/100ps

module permuteCheck import funcPkg::*; (
    input  boolFunc top,
    input  boolFunc bot,
    output permSet  perms
);

    boolFunc [NUM_PERMS-1:0] permBots; // bot with A, B, C reordered
    boolFunc [NUM_PERMS-1:0] outside;  // permuted bot bits not covered by top

    // pure rewiring, each output bit picks one bot bit
    always_comb begin
        for (int p = 0; p < NUM_PERMS; p++) begin
            for (int k = 0; k < FUNC_BITS; k++) begin
                permBots[p][k] = bot[srcIndex(permId'(p), FUNC_VARS'(k))];
            end
        end
    end

    // valid when no bit of the permuted bot falls outside top
    always_comb begin
        for (int p = 0; p < NUM_PERMS; p++) begin
            outside[p]         = permBots[p] & ~top;
            perms.validMask[p] = ~|outside[p];
            perms.bots[p]      = permBots[p]; // mask order ABC at bit 5 down to CBA at bit 0
        end
    end

endmodule

//--- src/pipelineManager.sv
`timescale 1ns/100ps

module pipelineManager import funcPkg::*, streamPkg::*; #(
    parameter int BUF_DEPTH = 32
) (
    input  logic    clock,
    input  logic    rst,
    input  logic    ivalid,
    input  logic    startNewTop,
    input  boolFunc botIn,
    input  permSet  perms,
    input  logic    popStrobe,
    output logic    oready,
    output boolFunc top,
    output logic    acceptStrobe,
    output stageRec stage
);

    localparam int CREDIT_BITS = $clog2(BUF_DEPTH) + 1; // holds 0..BUF_DEPTH

    mgrState                state;
    mgrState                nextState;
    logic [CREDIT_BITS-1:0] credits;     // free slots in the output buffer
    logic [CREDIT_BITS-1:0] nextCredits;
    logic [INDEX_BITS-1:0]  botIndex;    // index the next bot will carry
    logic                   transfer;
    logic                   topLoad;
    logic                   botAccept;

    assign transfer  = ivalid && oready;
    assign topLoad   = transfer && startNewTop; // word becomes the new top, no result
    assign botAccept = transfer && !startNewTop;

    always_comb begin
        case (state)
            RUN:     nextState = topLoad ? LOAD_TOP : RUN;
            default: nextState = RUN; // single idle cycle after a top load
        endcase
    end

    // a bot spends a slot, an output transfer gives one back
    assign nextCredits = credits - CREDIT_BITS'(botAccept) + CREDIT_BITS'(popStrobe);

    always_ff @(posedge clock) begin
        if (rst) begin
            state        <= RUN;
            credits      <= CREDIT_BITS'(BUF_DEPTH);
            oready       <= 1'b0;
            top          <= '0;
            botIndex     <= '0;
            acceptStrobe <= 1'b0;
        end else begin
            state        <= nextState;
            credits      <= nextCredits;
            oready       <= (nextState == RUN) && (nextCredits != '0); // registered ready
            acceptStrobe <= botAccept;
            if (topLoad) begin
                top      <= botIn;
                botIndex <= '0; // results restart at index 0
            end else if (botAccept) begin
                botIndex <= botIndex + 1'b1;
            end
        end
    end

    // permSet was formed against the top in force at this edge
    always_ff @(posedge clock) begin
        if (botAccept) begin
            stage <= '{botIndex: botIndex, perms: perms};
        end
    end

    // wrap in either direction lands above BUF_DEPTH
    creditRange: assert property (@(posedge clock) disable iff (rst)
        credits <= CREDIT_BITS'(BUF_DEPTH))
        else $error("credit counter left 0..%0d", BUF_DEPTH);

endmodule

//--- src/countPipeline.sv
`timescale 1ns/100ps

module countPipeline import funcPkg::*, streamPkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  boolFunc   top,
    input  logic      acceptStrobe,
    input  stageRec   stage,
    output logic      resultValid,
    output resultWord result
);

    logic                              valid1;
    logic                              valid2;
    logic [INDEX_BITS-1:0]             index1;
    logic [INDEX_BITS-1:0]             index2;
    boolFunc [NUM_PERMS-1:0]           uncovered1; // top bits the permuted bot misses
    logic [NUM_PERMS-1:0]              mask1;
    logic [NUM_PERMS-1:0][POP_BITS-1:0] counts2;   // one popcount per permutation
    logic [COUNT_BITS-1:0]             pcoeff2;
    logic [SUM_BITS-1:0]               summedNext;

    function automatic logic [POP_BITS-1:0] popCount(boolFunc f);
        logic [POP_BITS-1:0] n;
        n = '0;
        for (int i = 0; i < FUNC_BITS; i++) begin
            n = n + POP_BITS'(f[i]);
        end
        return n;
    endfunction

    always_comb begin
        summedNext = '0;
        for (int p = 0; p < NUM_PERMS; p++) begin
            summedNext = summedNext + SUM_BITS'(counts2[p]); // at most 6 * 128
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            valid1      <= 1'b0;
            valid2      <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            valid1      <= acceptStrobe;
            valid2      <= valid1;
            resultValid <= valid2; // third edge after acceptance
        end
    end

    always_ff @(posedge clock) begin
        // stage 1, invalid permutations contribute nothing
        index1 <= stage.botIndex;
        mask1  <= stage.perms.validMask;
        for (int p = 0; p < NUM_PERMS; p++) begin
            uncovered1[p] <= stage.perms.validMask[p] ? (top & ~stage.perms.bots[p]) : '0;
        end
        // stage 2
        index2  <= index1;
        pcoeff2 <= COUNT_BITS'(popCount(FUNC_BITS'(mask1)));
        for (int p = 0; p < NUM_PERMS; p++) begin
            counts2[p] <= popCount(uncovered1[p]);
        end
        // stage 3
        result.botIndex    <= index2;
        result.pcoeffCount <= pcoeff2;
        result.summedData  <= summedNext;
    end

    pcoeffRange: assert property (@(posedge clock) disable iff (rst)
        resultValid |-> result.pcoeffCount <= COUNT_BITS'(NUM_PERMS))
        else $error("pcoeffCount above %0d", NUM_PERMS);

endmodule

//--- src/outputBuffer.sv
`timescale 1ns/100ps

module outputBuffer import streamPkg::*; #(
    parameter int BUF_DEPTH = 32
) (
    input  logic      clock,
    input  logic      rst,
    input  logic      resultValid,
    input  resultWord result,
    input  logic      iready,
    output logic      ovalid,
    output resultWord dataOut,
    output logic      popStrobe
);

    localparam int ADDR_BITS = $clog2(BUF_DEPTH);

    resultWord            mem [BUF_DEPTH];
    logic [ADDR_BITS-1:0] wrPtr;  // wraps, depth is a power of two
    logic [ADDR_BITS-1:0] rdPtr;
    logic [ADDR_BITS:0]   fill;   // words stored, 0..BUF_DEPTH

    assign ovalid    = (fill != '0);     // head word is ready
    assign dataOut   = mem[rdPtr];       // fall through
    assign popStrobe = ovalid && iready; // output transfer

    always_ff @(posedge clock) begin
        if (resultValid) begin
            mem[wrPtr] <= result;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (resultValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popStrobe) begin
                rdPtr <= rdPtr + 1'b1;
            end
            fill <= fill + (ADDR_BITS+1)'(resultValid) - (ADDR_BITS+1)'(popStrobe);
        end
    end

    // credits upstream keep this from happening
    noOverflow: assert property (@(posedge clock) disable iff (rst)
        !(resultValid && fill == (ADDR_BITS+1)'(BUF_DEPTH)))
        else $error("write into a full output buffer");

    // stalled head word must not move
    holdOnStall: assert property (@(posedge clock) disable iff (rst)
        ovalid && !iready |=> ovalid && $stable(dataOut))
        else $error("output changed while stalled");

endmodule

//--- src/openCLFullPipeline.sv
`timescale 1ns/100ps

module openCLFullPipeline import funcPkg::*, streamPkg::*; #(
    parameter int BUF_DEPTH = 32
) (
    input  logic        clock,
    input  logic        rst,
    input  logic        ivalid,
    input  logic        iready,
    output logic        ovalid,
    output logic        oready,
    input  logic        startNewTop,  // bot input carries a new top
    input  logic [63:0] botLower,
    input  logic [63:0] botUpper,
    output resultWord   summedDataPcoeffCountOut
);

    boolFunc   bot;
    boolFunc   top;
    permSet    perms;
    logic      acceptStrobe;
    stageRec   stage;
    logic      resultValid;
    resultWord result;
    logic      popStrobe;

    assign bot = {botUpper, botLower};

    // combinational, checks the incoming bot against the current top
    permuteCheck permuteChecker (
        .top   (top),
        .bot   (bot),
        .perms (perms)
    );

    pipelineManager #(
        .BUF_DEPTH (BUF_DEPTH)
    ) pipelineMngr (
        .clock        (clock),
        .rst          (rst),
        .ivalid       (ivalid),
        .startNewTop  (startNewTop),
        .botIn        (bot),          // also the top source
        .perms        (perms),
        .popStrobe    (popStrobe),    // credit return
        .oready       (oready),
        .top          (top),
        .acceptStrobe (acceptStrobe),
        .stage        (stage)
    );

    countPipeline countPipe (
        .clock        (clock),
        .rst          (rst),
        .top          (top),
        .acceptStrobe (acceptStrobe),
        .stage        (stage),
        .resultValid  (resultValid),
        .result       (result)
    );

    outputBuffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) resultsBuf (
        .clock       (clock),
        .rst         (rst),
        .resultValid (resultValid),
        .result      (result),
        .iready      (iready),
        .ovalid      (ovalid),
        .dataOut     (summedDataPcoeffCountOut),
        .popStrobe   (popStrobe)
    );

endmodule

//--- dv/resultChecker.sv
`timescale 1ns/100ps

module resultChecker import streamPkg::*; (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  ivalid,
    input  logic                  oready,
    input  logic                  startNewTop,
    input  logic [63:0]           botLower,
    input  logic [63:0]           botUpper,
    input  logic                  ovalid,
    input  logic                  iready,
    input  resultWord             dataOut,
    input  logic [COUNT_BITS-1:0] expCount,  // table expectation travelling with the row
    input  logic [SUM_BITS-1:0]   expSum,
    input  logic [2:0]            groupId,
    input  logic                  endRun,
    output int                    errorCount,
    output int                    resultCount,
    output int                    pending
);

    typedef struct packed {
        logic [2:0] grp;
        resultWord  word;
    } expectRec;

    string        groupNames [6] = '{"zeroTop", "onesTop", "crafted", "reload", "stall", "random"};
    expectRec     expected [$];  // accepted bots still waiting for their result
    logic [127:0] curTop = '0;   // top as seen on the input port
    int unsigned  nextIndex = 0;
    int           curGroup = -1;
    int           grpChecks = 0;
    int           grpErrors = 0;
    int           errs = 0;
    int           results = 0;
    int           depth = 0;
    logic         reported = 1'b0;

    assign errorCount  = errs;
    assign resultCount = results;
    assign pending     = depth;

    // count of valid reorderings of A, B, C and the top bits they leave uncovered
    function automatic logic [COUNT_BITS+SUM_BITS-1:0] refResult(logic [127:0] topF,
                                                                 logic [127:0] botF);
        int           order [6][3] = '{'{0, 1, 2}, '{0, 2, 1}, '{1, 0, 2},
                                       '{1, 2, 0}, '{2, 0, 1}, '{2, 1, 0}};
        logic [127:0] pb;
        int           src;
        int           cnt;
        int           sum;
        cnt = 0;
        sum = 0;
        for (int p = 0; p < 6; p++) begin
            for (int k = 0; k < 128; k++) begin
                src = k & 15; // low four variables stay put
                for (int j = 0; j < 3; j++) begin
                    src += ((k >> (4 + j)) & 1) << (4 + order[p][j]);
                end
                pb[k] = botF[src];
            end
            if ((pb & ~topF) == '0) begin
                cnt++;
                sum += $countones(topF & ~pb);
            end
        end
        return {COUNT_BITS'(cnt), SUM_BITS'(sum)};
    endfunction

    task automatic compareField(string name, logic [63:0] expV, logic [63:0] obsV);
        if (expV !== obsV) begin
            $display("ERROR %s expected %h observed %h", name, expV, obsV);
            errs++;
            grpErrors++;
        end
    endtask

    task automatic closeGroup();
        if (curGroup >= 0) begin
            $display("group %-8s %0d results, %0d errors", groupNames[curGroup], grpChecks,
                     grpErrors);
        end
    endtask

    always @(posedge clock) begin : monitor
        expectRec                       e;
        logic [COUNT_BITS+SUM_BITS-1:0] model;
        if (!rst) begin
            if (ivalid && oready) begin
                if (startNewTop) begin
                    curTop    = {botUpper, botLower};
                    nextIndex = 0; // numbering restarts with each top
                end else begin
                    model = refResult(curTop, {botUpper, botLower});
                    if (model != {expCount, expSum}) begin
                        $display("table row for bot %0d of group %s disagrees with the model",
                                 nextIndex, groupNames[groupId]);
                        errs++;
                    end
                    e.grp              = groupId;
                    e.word.botIndex    = INDEX_BITS'(nextIndex);
                    e.word.pcoeffCount = expCount;
                    e.word.summedData  = expSum;
                    expected.push_back(e);
                    nextIndex++;
                end
            end
            if (ovalid && iready) begin
                if (expected.size() == 0) begin
                    $display("a result left the DUT with no accepted bot waiting for it");
                    errs++;
                end else begin
                    e = expected.pop_front();
                    if (e.grp != curGroup) begin
                        closeGroup(); // first result of a new group ends the previous one
                        curGroup  = e.grp;
                        grpChecks = 0;
                        grpErrors = 0;
                    end
                    results++;
                    grpChecks++;
                    compareField("summedDataPcoeffCountOut.botIndex", e.word.botIndex,
                                 dataOut.botIndex);
                    compareField("summedDataPcoeffCountOut.pcoeffCount", e.word.pcoeffCount,
                                 dataOut.pcoeffCount);
                    compareField("summedDataPcoeffCountOut.summedData", e.word.summedData,
                                 dataOut.summedData);
                end
            end
            depth <= expected.size(); // seen by the driver one edge later
            if (endRun && !reported) begin
                closeGroup();
                reported = 1'b1;
            end
        end
    end

endmodule

//--- dv/tbTop.sv
`timescale 1ns/100ps

module tbTop import streamPkg::*; ();

    localparam int BUF_DEPTH = 8;

    typedef struct packed {
        logic                  newTop;
        logic [127:0]          word;
        logic [COUNT_BITS-1:0] cnt;
        logic [SUM_BITS-1:0]   sum;
        logic [2:0]            grp;
    } stimRow;

    logic                  clock;
    logic                  rst;
    logic                  ivalid;
    logic                  iready;
    logic                  ovalid;
    logic                  oready;
    logic                  startNewTop;
    logic [63:0]           botLower;
    logic [63:0]           botUpper;
    resultWord             dataOut;
    logic [COUNT_BITS-1:0] expCount;
    logic [SUM_BITS-1:0]   expSum;
    logic [2:0]            groupId;
    logic                  endRun;
    int                    errorCount;
    int                    resultCount;
    int                    pending;
    stimRow                rows [$];
    logic [127:0]          modelTop;        // top in force while the table is built
    int                    tbErrors;
    logic                  sawBackPressure;
    logic                  tableReady;

    openCLFullPipeline #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_dut (
        .clock                    (clock),
        .rst                      (rst),
        .ivalid                   (ivalid),
        .iready                   (iready),
        .ovalid                   (ovalid),
        .oready                   (oready),
        .startNewTop              (startNewTop),
        .botLower                 (botLower),
        .botUpper                 (botUpper),
        .summedDataPcoeffCountOut (dataOut)
    );

    resultChecker i_checker (.*);

    function automatic logic [127:0] oneHot(int n);
        return 128'h1 << n;
    endfunction

    function automatic logic [127:0] randomFunc();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic tableRow(input logic newTop, input logic [127:0] word,
                            input logic [COUNT_BITS-1:0] cnt, input logic [SUM_BITS-1:0] sum,
                            input logic [2:0] grp);
        rows.push_back('{newTop, word, cnt, sum, grp});
        if (newTop) begin
            modelTop = word;
        end
    endtask

    // expected fields come from the checker's model, top rows ignore them
    task automatic modelledRow(input logic newTop, input logic [127:0] word, input logic [2:0] grp);
        logic [COUNT_BITS+SUM_BITS-1:0] model;
        model = i_checker.refResult(modelTop, word);
        tableRow(newTop, word, model[SUM_BITS +: COUNT_BITS], model[SUM_BITS-1:0], grp);
    endtask

    task automatic buildTable();
        logic [127:0] top;
        tableRow(0, '0, 6, 0, 0);                  // zero top, only the empty bot fits
        tableRow(0, oneHot(0), 0, 0, 0);
        tableRow(0, oneHot(127), 0, 0, 0);
        tableRow(0, ~128'h0, 0, 0, 0);
        tableRow(1, ~128'h0, 0, 0, 1);             // all-ones top
        tableRow(0, '0, 6, 768, 1);
        tableRow(0, ~128'h0, 6, 0, 1);
        tableRow(0, oneHot(0), 6, 762, 1);
        tableRow(0, oneHot(16) | oneHot(100), 6, 756, 1);
        tableRow(1, oneHot(16) | oneHot(32) | oneHot(64), 0, 0, 2); // A, B, C one-hot
        tableRow(0, oneHot(16), 6, 12, 2);
        tableRow(0, oneHot(16) | oneHot(32), 6, 6, 2);
        tableRow(0, oneHot(48), 0, 0, 2);
        tableRow(0, oneHot(0), 0, 0, 2);
        tableRow(1, oneHot(16) | oneHot(32), 0, 0, 2);
        tableRow(0, oneHot(16), 4, 4, 2);
        tableRow(0, oneHot(16) | oneHot(32), 2, 0, 2);
        tableRow(1, oneHot(16) | oneHot(48), 0, 0, 2);
        tableRow(0, oneHot(16) | oneHot(48), 1, 0, 2); // only the identity fits
        tableRow(0, oneHot(16), 2, 2, 2);
        tableRow(1, oneHot(16) | oneHot(32) | oneHot(48) | oneHot(80), 0, 0, 2);
        tableRow(0, oneHot(16) | oneHot(48), 3, 6, 2);
        tableRow(1, ~128'h0, 0, 0, 3);             // two loads back to back
        tableRow(1, oneHot(5) | oneHot(21), 0, 0, 3);
        tableRow(0, oneHot(5), 6, 6, 3);
        tableRow(0, oneHot(21), 2, 2, 3);
        top = randomFunc() | randomFunc();         // dense top for the stall group
        modelledRow(1, top, 4);
        repeat (24) modelledRow(0, randomFunc() & randomFunc() & top, 4);
        repeat (4) begin
            top = randomFunc() | randomFunc() | randomFunc();
            modelledRow(1, top, 5);
            repeat (3) modelledRow(0, randomFunc() & top, 5);
            repeat (2) modelledRow(0, randomFunc() & randomFunc() & randomFunc() & top, 5);
            modelledRow(0, randomFunc(), 5);       // mostly outside top
        end
    endtask

    // hold the row until the DUT takes it
    task automatic applyRow(input stimRow r);
        int gap;
        int waited;
        gap    = $urandom_range(0, 2);
        waited = 0;
        if (gap > 0) begin
            ivalid <= 1'b0;
            repeat (gap) @(posedge clock);
        end
        ivalid      <= 1'b1;
        startNewTop <= r.newTop;
        botLower    <= r.word[63:0];
        botUpper    <= r.word[127:64];
        expCount    <= r.cnt;
        expSum      <= r.sum;
        groupId     <= r.grp;
        @(posedge clock);
        while (!oready) begin
            waited++;
            @(posedge clock);
        end
        if (r.grp == 4 && waited > 1) sawBackPressure = 1'b1; // longer than the top-load gap
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        void'($urandom(32'hd2d));
        rst             = 1'b1;
        ivalid          = 1'b0;
        iready          = 1'b0;
        startNewTop     = 1'b0;
        botLower        = '0;
        botUpper        = '0;
        expCount        = '0;
        expSum          = '0;
        groupId         = '0;
        endRun          = 1'b0;
        modelTop        = '0;
        tbErrors        = 0;
        sawBackPressure = 1'b0;
        tableReady      = 1'b0;
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clock);
        rst <= 1'b0;
        repeat (2) @(posedge clock);
        if (!oready || ovalid) begin
            $display("after reset oready was not high or ovalid was not low");
            tbErrors++;
        end
        foreach (rows[r]) applyRow(rows[r]);
        ivalid <= 1'b0;
        repeat (2) @(posedge clock); // let the last push reach pending
        while (pending != 0) @(posedge clock);
        endRun <= 1'b1;
        repeat (2) @(posedge clock);
        if (!sawBackPressure) begin
            $display("oready never fell while the output was stalled");
            tbErrors++;
        end
        $display("%0d results checked, %0d errors", resultCount, errorCount + tbErrors);
        if (errorCount == 0 && tbErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // downstream stalls, one long burst at the start of the stall group
    initial begin : stallPattern
        logic burstDone;
        burstDone = 1'b0;
        forever begin
            @(posedge clock);
            if (groupId == 4 && !burstDone) begin
                burstDone = 1'b1;
                iready <= 1'b0;
                repeat (30) @(posedge clock);
            end else if ($urandom_range(0, 40) == 0) begin
                iready <= 1'b0;
                repeat ($urandom_range(8, 20)) @(posedge clock);
            end else begin
                iready <= ($urandom_range(0, 3) != 0);
            end
        end
    end

    initial begin : watchdog
        wait (tableReady);
        repeat (rows.size() * 40 + 200) @(posedge clock);
        $display("timeout with %0d results never delivered", pending);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- tb.f
src/funcPkg.sv
src/streamPkg.sv
src/permuteCheck.sv
src/pipelineManager.sv
src/countPipeline.sv
src/outputBuffer.sv
src/openCLFullPipeline.sv
dv/resultChecker.sv
dv/tbTop.sv

//--- Bender.yml
package:
  name: openclpipeline

sources:
  - src/funcPkg.sv
  - src/streamPkg.sv
  - src/permuteCheck.sv
  - src/pipelineManager.sv
  - src/countPipeline.sv
  - src/outputBuffer.sv
  - src/openCLFullPipeline.sv
  - target: test
    files:
      - dv/resultChecker.sv
      - dv/tbTop.sv
